/* design/biquad_pkg.sv */
package biquad_pkg;

  // --------------------------------------------------
  // Data path sizes
  // --------------------------------------------------
  localparam int COEF_W    = 16;
  localparam int Q_BITS    = 12;                 // Q3.12 signed
  localparam int ONE_Q     = 1 << Q_BITS;
  localparam int ACC_W     = 2 * COEF_W + 3;     // Room for five products
  localparam int QUOT_BITS = COEF_W + Q_BITS;    // Divider iterations
  localparam int STEP_W    = $clog2(QUOT_BITS);
  localparam int COEF_MAX  = 32767;
  localparam int COEF_MIN  = -32768;
  localparam int CNT_W     = 16;

  // --------------------------------------------------
  // APB register map
  // --------------------------------------------------
  localparam int APB_DATA_W = 32;
  localparam int APB_ADDR_W = 8;

  localparam logic [APB_ADDR_W-1:0] REG_CTRL    = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_RAW_B0  = 8'h04;
  localparam logic [APB_ADDR_W-1:0] REG_RAW_B1  = 8'h08;
  localparam logic [APB_ADDR_W-1:0] REG_RAW_B2  = 8'h0C;
  localparam logic [APB_ADDR_W-1:0] REG_RAW_A0  = 8'h10;
  localparam logic [APB_ADDR_W-1:0] REG_RAW_A1  = 8'h14;
  localparam logic [APB_ADDR_W-1:0] REG_RAW_A2  = 8'h18;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS  = 8'h20;
  localparam logic [APB_ADDR_W-1:0] REG_NRM_B0  = 8'h24;
  localparam logic [APB_ADDR_W-1:0] REG_NRM_B1  = 8'h28;
  localparam logic [APB_ADDR_W-1:0] REG_NRM_B2  = 8'h2C;
  localparam logic [APB_ADDR_W-1:0] REG_NRM_A1  = 8'h30;
  localparam logic [APB_ADDR_W-1:0] REG_NRM_A2  = 8'h34;
  localparam logic [APB_ADDR_W-1:0] REG_OVF_CNT = 8'h38;

  // --------------------------------------------------
  // State and selector types
  // --------------------------------------------------
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_QUOT,
    COMMIT
  } seq_state_t;

  // Order also sets the normalized read-back layout
  typedef enum logic [2:0] {
    SEL_B0,
    SEL_B1,
    SEL_B2,
    SEL_A1,
    SEL_A2
  } coef_sel_t;

endpackage

/* design/biquad_apb_regs.sv */
`timescale 1ns/1ps

module biquad_apb_regs (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic        [biquad_pkg::APB_ADDR_W-1:0] paddr,
  input  logic        [biquad_pkg::APB_DATA_W-1:0] pwdata,
  output logic        [biquad_pkg::APB_DATA_W-1:0] prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  input  logic                                  busy,
  input  logic                                  ovf_pulse,
  input  logic signed [biquad_pkg::COEF_W-1:0]     nrm_b0,
  input  logic signed [biquad_pkg::COEF_W-1:0]     nrm_b1,
  input  logic signed [biquad_pkg::COEF_W-1:0]     nrm_b2,
  input  logic signed [biquad_pkg::COEF_W-1:0]     nrm_a1,
  input  logic signed [biquad_pkg::COEF_W-1:0]     nrm_a2,
  output logic signed [biquad_pkg::COEF_W-1:0]     raw_b0,
  output logic signed [biquad_pkg::COEF_W-1:0]     raw_b1,
  output logic signed [biquad_pkg::COEF_W-1:0]     raw_b2,
  output logic signed [biquad_pkg::COEF_W-1:0]     raw_a0,
  output logic signed [biquad_pkg::COEF_W-1:0]     raw_a1,
  output logic signed [biquad_pkg::COEF_W-1:0]     raw_a2,
  output logic                                  bypass,
  output logic                                  recalc_req
);
  import biquad_pkg::*;

  logic                   access;
  logic                   mapped;
  logic                   read_only;
  logic                   raw_hit;
  logic                   wr_en;
  logic                   pending;
  coef_sel_t              nrm_sel;
  logic [COEF_W-1:0]      nrm_rd;
  logic [CNT_W-1:0]       ovf_cnt;

  function automatic logic [APB_DATA_W-1:0] sext(logic signed [COEF_W-1:0] v);
    return APB_DATA_W'(v);
  endfunction

  assign access  = psel && penable;
  assign pready  = 1'b1;                          // No wait states
  assign pslverr = access && (!mapped || (pwrite && read_only));
  assign wr_en   = access && pwrite && mapped && !read_only;
  assign nrm_sel = coef_sel_t'(3'((paddr - REG_NRM_B0) >> 2));

  always_comb begin
    case (nrm_sel)
      SEL_B0:  nrm_rd = nrm_b0;
      SEL_B1:  nrm_rd = nrm_b1;
      SEL_B2:  nrm_rd = nrm_b2;
      SEL_A1:  nrm_rd = nrm_a1;
      default: nrm_rd = nrm_a2;
    endcase
  end

  // --------------------------------------------------
  // Address decode and read-back
  // --------------------------------------------------
  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b0;
    raw_hit   = 1'b0;
    prdata    = '0;
    case (paddr)
      REG_CTRL:    prdata = APB_DATA_W'(bypass);
      REG_RAW_B0:  begin raw_hit = 1'b1; prdata = sext(raw_b0); end
      REG_RAW_B1:  begin raw_hit = 1'b1; prdata = sext(raw_b1); end
      REG_RAW_B2:  begin raw_hit = 1'b1; prdata = sext(raw_b2); end
      REG_RAW_A0:  begin raw_hit = 1'b1; prdata = sext(raw_a0); end
      REG_RAW_A1:  begin raw_hit = 1'b1; prdata = sext(raw_a1); end
      REG_RAW_A2:  begin raw_hit = 1'b1; prdata = sext(raw_a2); end
      REG_STATUS:  begin read_only = 1'b1; prdata = APB_DATA_W'(busy); end
      REG_NRM_B0, REG_NRM_B1, REG_NRM_B2, REG_NRM_A1, REG_NRM_A2: begin
        read_only = 1'b1;
        prdata    = sext(nrm_rd);
      end
      REG_OVF_CNT: begin read_only = 1'b1; prdata = APB_DATA_W'(ovf_cnt); end
      default:     mapped = 1'b0;
    endcase
  end

  // --------------------------------------------------
  // Writable registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bypass <= 1'b0;
      raw_b0 <= COEF_W'(ONE_Q);                    // Identity filter
      raw_b1 <= '0;
      raw_b2 <= '0;
      raw_a0 <= COEF_W'(ONE_Q);
      raw_a1 <= '0;
      raw_a2 <= '0;
    end else if (wr_en) begin
      case (paddr)
        REG_CTRL:   bypass <= pwdata[0];
        REG_RAW_B0: raw_b0 <= pwdata[COEF_W-1:0];
        REG_RAW_B1: raw_b1 <= pwdata[COEF_W-1:0];
        REG_RAW_B2: raw_b2 <= pwdata[COEF_W-1:0];
        REG_RAW_A0: raw_a0 <= pwdata[COEF_W-1:0];
        REG_RAW_A1: raw_a1 <= pwdata[COEF_W-1:0];
        REG_RAW_A2: raw_a2 <= pwdata[COEF_W-1:0];
        default: ;
      endcase
    end
  end

  // Recalculation request, a write during a run queues one more
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending    <= 1'b0;
      recalc_req <= 1'b0;
    end else begin
      recalc_req <= 1'b0;
      if (pending && !busy && !recalc_req) begin
        recalc_req <= 1'b1;
        pending    <= 1'b0;
      end
      if (wr_en && raw_hit) pending <= 1'b1;        // Wins over the clear
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ovf_cnt <= '0;
    end else if (ovf_pulse && ovf_cnt != '1) begin
      ovf_cnt <= ovf_cnt + 1'b1;                    // Saturating count
    end
  end

endmodule

/* design/coef_sequencer.sv */
`timescale 1ns/1ps

module coef_sequencer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              recalc_req,
  input  logic signed [biquad_pkg::COEF_W-1:0] raw_b0,
  input  logic signed [biquad_pkg::COEF_W-1:0] raw_b1,
  input  logic signed [biquad_pkg::COEF_W-1:0] raw_b2,
  input  logic signed [biquad_pkg::COEF_W-1:0] raw_a0,
  input  logic signed [biquad_pkg::COEF_W-1:0] raw_a1,
  input  logic signed [biquad_pkg::COEF_W-1:0] raw_a2,
  output logic                              busy,
  output logic                              div_in_valid,
  input  logic                              div_in_ready,
  output logic signed [biquad_pkg::COEF_W-1:0] div_dividend,
  output logic signed [biquad_pkg::COEF_W-1:0] div_divisor,
  input  logic                              div_out_valid,
  input  logic signed [biquad_pkg::COEF_W-1:0] div_quotient,
  input  logic                              div_ovf,
  output logic signed [biquad_pkg::COEF_W-1:0] nrm_b0,
  output logic signed [biquad_pkg::COEF_W-1:0] nrm_b1,
  output logic signed [biquad_pkg::COEF_W-1:0] nrm_b2,
  output logic signed [biquad_pkg::COEF_W-1:0] nrm_a1,
  output logic signed [biquad_pkg::COEF_W-1:0] nrm_a2,
  output logic                              ovf_pulse
);
  import biquad_pkg::*;

  seq_state_t               state;
  coef_sel_t                sel;
  logic                     result;
  logic signed [COEF_W-1:0] cap_b0, cap_b1, cap_b2, cap_a0, cap_a1, cap_a2;
  logic signed [COEF_W-1:0] shd_b0, shd_b1, shd_b2, shd_a1, shd_a2;

  assign busy         = (state != IDLE);
  assign div_in_valid = (state == ISSUE);           // Held until accepted
  assign div_divisor  = cap_a0;
  assign result       = (state == WAIT_QUOT) && div_out_valid;
  assign ovf_pulse    = result && div_ovf;

  always_comb begin
    case (sel)
      SEL_B0:  div_dividend = cap_b0;
      SEL_B1:  div_dividend = cap_b1;
      SEL_B2:  div_dividend = cap_b2;
      SEL_A1:  div_dividend = cap_a1;
      default: div_dividend = cap_a2;
    endcase
  end

  // --------------------------------------------------
  // Division sequence FSM
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      sel   <= SEL_B0;
    end else begin
      case (state)
        IDLE: begin
          if (recalc_req) begin
            sel   <= SEL_B0;
            state <= ISSUE;
          end
        end
        ISSUE: if (div_in_ready) state <= WAIT_QUOT;
        WAIT_QUOT: begin
          if (div_out_valid) begin
            if (sel == SEL_A2) begin
              state <= COMMIT;
            end else begin
              sel   <= coef_sel_t'(sel + 3'd1);
              state <= ISSUE;
            end
          end
        end
        default: state <= IDLE;                      // COMMIT lasts one cycle
      endcase
    end
  end

  // Snapshot of the raw set and the collected quotients
  always_ff @(posedge clk) begin
    if (state == IDLE && recalc_req) begin
      cap_b0 <= raw_b0;
      cap_b1 <= raw_b1;
      cap_b2 <= raw_b2;
      cap_a0 <= raw_a0;
      cap_a1 <= raw_a1;
      cap_a2 <= raw_a2;
    end
    if (result) begin
      case (sel)
        SEL_B0:  shd_b0 <= div_quotient;
        SEL_B1:  shd_b1 <= div_quotient;
        SEL_B2:  shd_b2 <= div_quotient;
        SEL_A1:  shd_a1 <= div_quotient;
        default: shd_a2 <= div_quotient;
      endcase
    end
  end

  // Active set, all five switch together
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nrm_b0 <= COEF_W'(ONE_Q);
      nrm_b1 <= '0;
      nrm_b2 <= '0;
      nrm_a1 <= '0;
      nrm_a2 <= '0;
    end else if (state == COMMIT) begin
      nrm_b0 <= shd_b0;
      nrm_b1 <= shd_b1;
      nrm_b2 <= shd_b2;
      nrm_a1 <= shd_a1;
      nrm_a2 <= shd_a2;
    end
  end

endmodule

/* design/serial_divider.sv */
`timescale 1ns/1ps

module serial_divider (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              in_valid,
  output logic                              in_ready,
  input  logic signed [biquad_pkg::COEF_W-1:0] dividend,
  input  logic signed [biquad_pkg::COEF_W-1:0] divisor,
  output logic                              out_valid,
  output logic signed [biquad_pkg::COEF_W-1:0] quotient,
  output logic                              ovf
);
  import biquad_pkg::*;

  typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_t;

  div_state_t          state;
  logic [STEP_W-1:0]   step;
  logic [QUOT_BITS-1:0] num;                        // Quotient bits shift in at the bottom
  logic [COEF_W:0]     rem;
  logic [COEF_W:0]     trial;
  logic [COEF_W-1:0]   den;
  logic [COEF_W-1:0]   mag_dd;
  logic [COEF_W-1:0]   mag_dv;
  logic                neg;
  logic                dz;
  logic                dd_neg;

  assign in_ready  = (state == DIV_IDLE);
  assign out_valid = (state == DIV_DONE);
  assign mag_dd    = dividend[COEF_W-1] ? -dividend : dividend;
  assign mag_dv    = divisor[COEF_W-1] ? -divisor : divisor;
  assign trial     = {rem[COEF_W-1:0], num[QUOT_BITS-1]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= DIV_IDLE;
      step  <= '0;
    end else begin
      case (state)
        DIV_IDLE: begin
          step <= '0;
          if (in_valid) state <= DIV_RUN;
        end
        DIV_RUN: begin
          step <= step + 1'b1;
          if (step == STEP_W'(QUOT_BITS - 1)) state <= DIV_DONE;
        end
        default: state <= DIV_IDLE;                  // Result shown for one cycle
      endcase
    end
  end

  // Restoring shift-subtract on the magnitudes
  always_ff @(posedge clk) begin
    if (state == DIV_IDLE && in_valid) begin
      num    <= {mag_dd, Q_BITS'(0)};
      rem    <= '0;
      den    <= mag_dv;
      neg    <= dividend[COEF_W-1] ^ divisor[COEF_W-1];
      dd_neg <= dividend[COEF_W-1];
      dz     <= (divisor == '0);
    end else if (state == DIV_RUN) begin
      if (trial >= {1'b0, den}) begin
        rem <= trial - {1'b0, den};
        num <= {num[QUOT_BITS-2:0], 1'b1};
      end else begin
        rem <= trial;
        num <= {num[QUOT_BITS-2:0], 1'b0};
      end
    end
  end

  // Sign and saturation
  always_comb begin
    ovf = 1'b1;
    if (dz) begin
      quotient = dd_neg ? COEF_W'(COEF_MIN) : COEF_W'(COEF_MAX);
    end else if (neg && num > QUOT_BITS'(-COEF_MIN)) begin
      quotient = COEF_W'(COEF_MIN);
    end else if (!neg && num > QUOT_BITS'(COEF_MAX)) begin
      quotient = COEF_W'(COEF_MAX);
    end else begin
      ovf      = 1'b0;
      quotient = neg ? COEF_W'(-num) : COEF_W'(num);
    end
  end

endmodule

/* design/biquad_core.sv */
`timescale 1ns/1ps

module biquad_core (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              x_valid,
  input  logic signed [biquad_pkg::COEF_W-1:0] x,
  input  logic                              bypass,
  input  logic signed [biquad_pkg::COEF_W-1:0] b0,
  input  logic signed [biquad_pkg::COEF_W-1:0] b1,
  input  logic signed [biquad_pkg::COEF_W-1:0] b2,
  input  logic signed [biquad_pkg::COEF_W-1:0] a1,
  input  logic signed [biquad_pkg::COEF_W-1:0] a2,
  output logic                              y_valid,
  output logic signed [biquad_pkg::COEF_W-1:0] y
);
  import biquad_pkg::*;

  logic signed [COEF_W-1:0] x1, x2;               // Input history
  logic signed [COEF_W-1:0] y1, y2;               // Filtered output history
  logic signed [ACC_W-1:0]  acc;
  logic signed [ACC_W-1:0]  acc_q;
  logic signed [COEF_W-1:0] y_filt;

  // --------------------------------------------------
  // Direct form I sum, full precision
  // --------------------------------------------------
  assign acc   = b0 * x + b1 * x1 + b2 * x2 - a1 * y1 - a2 * y2;
  assign acc_q = acc >>> Q_BITS;

  always_comb begin
    if (acc_q > COEF_MAX) begin
      y_filt = COEF_W'(COEF_MAX);
    end else if (acc_q < COEF_MIN) begin
      y_filt = COEF_W'(COEF_MIN);
    end else begin
      y_filt = COEF_W'(acc_q);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      y_valid <= 1'b0;
      x1      <= '0;
      x2      <= '0;
      y1      <= '0;
      y2      <= '0;
    end else begin
      y_valid <= x_valid;
      if (x_valid) begin
        x1 <= x;
        x2 <= x1;
        y1 <= y_filt;                                 // Kept even in bypass
        y2 <= y1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (x_valid) y <= bypass ? x : y_filt;
  end

endmodule

/* design/biquad_top.sv */
`timescale 1ns/1ps

module biquad_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic        [biquad_pkg::APB_ADDR_W-1:0] paddr,
  input  logic        [biquad_pkg::APB_DATA_W-1:0] pwdata,
  output logic        [biquad_pkg::APB_DATA_W-1:0] prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  input  logic                                  x_valid,
  input  logic signed [biquad_pkg::COEF_W-1:0]     x,
  output logic                                  y_valid,
  output logic signed [biquad_pkg::COEF_W-1:0]     y
);
  import biquad_pkg::*;

  logic signed [COEF_W-1:0] raw_b0, raw_b1, raw_b2, raw_a0, raw_a1, raw_a2;
  logic signed [COEF_W-1:0] nrm_b0, nrm_b1, nrm_b2, nrm_a1, nrm_a2;
  logic signed [COEF_W-1:0] div_dividend, div_divisor, div_quotient;
  logic                     bypass, recalc_req, busy, ovf_pulse;
  logic                     div_in_valid, div_in_ready, div_out_valid, div_ovf;

  // --------------------------------------------------
  // Register file and coefficient normalization
  // --------------------------------------------------
  biquad_apb_regs u_regs (
    .clk        (clk),        .rst_n      (rst_n),
    .psel       (psel),       .penable    (penable),
    .pwrite     (pwrite),     .paddr      (paddr),
    .pwdata     (pwdata),     .prdata     (prdata),
    .pready     (pready),     .pslverr    (pslverr),
    .busy       (busy),       .ovf_pulse  (ovf_pulse),
    .nrm_b0     (nrm_b0),     .nrm_b1     (nrm_b1),
    .nrm_b2     (nrm_b2),     .nrm_a1     (nrm_a1),
    .nrm_a2     (nrm_a2),
    .raw_b0     (raw_b0),     .raw_b1     (raw_b1),
    .raw_b2     (raw_b2),     .raw_a0     (raw_a0),
    .raw_a1     (raw_a1),     .raw_a2     (raw_a2),
    .bypass     (bypass),     .recalc_req (recalc_req)
  );

  coef_sequencer u_seq (
    .clk           (clk),           .rst_n         (rst_n),
    .recalc_req    (recalc_req),
    .raw_b0        (raw_b0),        .raw_b1        (raw_b1),
    .raw_b2        (raw_b2),        .raw_a0        (raw_a0),
    .raw_a1        (raw_a1),        .raw_a2        (raw_a2),
    .busy          (busy),
    .div_in_valid  (div_in_valid),  .div_in_ready  (div_in_ready),
    .div_dividend  (div_dividend),  .div_divisor   (div_divisor),
    .div_out_valid (div_out_valid), .div_quotient  (div_quotient),
    .div_ovf       (div_ovf),
    .nrm_b0        (nrm_b0),        .nrm_b1        (nrm_b1),
    .nrm_b2        (nrm_b2),        .nrm_a1        (nrm_a1),
    .nrm_a2        (nrm_a2),        .ovf_pulse     (ovf_pulse)
  );

  serial_divider u_div (
    .clk       (clk),           .rst_n     (rst_n),
    .in_valid  (div_in_valid),  .in_ready  (div_in_ready),
    .dividend  (div_dividend),  .divisor   (div_divisor),
    .out_valid (div_out_valid), .quotient  (div_quotient),
    .ovf       (div_ovf)
  );

  // Filter data path
  biquad_core u_core (
    .clk     (clk),     .rst_n   (rst_n),
    .x_valid (x_valid), .x       (x),
    .bypass  (bypass),
    .b0      (nrm_b0),  .b1      (nrm_b1),  .b2 (nrm_b2),
    .a1      (nrm_a1),  .a2      (nrm_a2),
    .y_valid (y_valid), .y       (y)
  );

endmodule

/* verif/biquad_chk.sv */
`timescale 1ns/1ps

module biquad_chk (
  input logic                                  clk,
  input logic                                  rst_n,
  input logic                                  psel,
  input logic                                  penable,
  input logic                                  pslverr,
  input logic                                  x_valid,
  input logic                                  y_valid,
  input logic                                  div_in_valid,
  input logic                                  div_in_ready,
  input logic                                  div_out_valid,
  input biquad_pkg::seq_state_t                seq_state,
  input logic signed [biquad_pkg::COEF_W-1:0]  nrm_b0,
  input logic signed [biquad_pkg::COEF_W-1:0]  nrm_b1,
  input logic signed [biquad_pkg::COEF_W-1:0]  nrm_b2,
  input logic signed [biquad_pkg::COEF_W-1:0]  nrm_a1,
  input logic signed [biquad_pkg::COEF_W-1:0]  nrm_a2
);
  import biquad_pkg::*;

  int unsigned             err_cnt = 0;          // Failed assertions so far
  logic [5*COEF_W-1:0]     nrm_all;

  assign nrm_all = {nrm_b0, nrm_b1, nrm_b2, nrm_a1, nrm_a2};

  // --------------------------------------------------
  // APB and sample stream
  // --------------------------------------------------
  a_slverr_access: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr |-> psel && penable)
    else begin
      err_cnt++;
      $error("pslverr high outside an access phase");
    end

  a_y_follows_x: assert property (@(posedge clk) disable iff (!rst_n)
    y_valid == $past(x_valid))
    else begin
      err_cnt++;
      $error("y_valid does not follow x_valid by one cycle");
    end

  // --------------------------------------------------
  // Divider latency and coefficient commit
  // --------------------------------------------------
  a_div_latency: assert property (@(posedge clk) disable iff (!rst_n)
    div_in_valid && div_in_ready |=> !div_out_valid [*QUOT_BITS] ##1 div_out_valid)
    else begin
      err_cnt++;
      $error("divider result not QUOT_BITS+1 cycles after handshake");
    end

  a_nrm_commit: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(nrm_all) |-> $past(seq_state) == COMMIT)
    else begin
      err_cnt++;
      $error("normalized set changed outside COMMIT");
    end

endmodule

bind biquad_top biquad_chk u_chk (
  .clk           (clk),           .rst_n         (rst_n),
  .psel          (psel),          .penable       (penable),
  .pslverr       (pslverr),
  .x_valid       (x_valid),       .y_valid       (y_valid),
  .div_in_valid  (div_in_valid),  .div_in_ready  (div_in_ready),
  .div_out_valid (div_out_valid), .seq_state     (u_seq.state),
  .nrm_b0        (nrm_b0),        .nrm_b1        (nrm_b1),
  .nrm_b2        (nrm_b2),        .nrm_a1        (nrm_a1),
  .nrm_a2        (nrm_a2)
);

/* verif/tb_biquad.sv */
`timescale 1ns/1ps

module tb_biquad;
  import biquad_pkg::*;

  localparam int     CLK_NS      = 10;
  // Eight normalization runs plus sample streams and APB traffic
  localparam int     TEST_CYCLES = 8 * 5 * (QUOT_BITS + 4) + 4 * 200 + 3 * 300;
  localparam longint WATCHDOG_NS = 6 * TEST_CYCLES * CLK_NS;
  localparam int     MAX_POLLS   = 400;
  // Unmapped or misaligned addresses
  localparam logic [4:0][7:0] BAD_ADDR = {8'h1C, 8'h3C, 8'h40, 8'h05, 8'hFC};

  logic                     clk;
  logic                     rst_n;
  logic                     psel, penable, pwrite;
  logic [APB_ADDR_W-1:0]    paddr;
  logic [APB_DATA_W-1:0]    pwdata, prdata;
  logic                     pready, pslverr;
  logic                     x_valid, y_valid;
  logic signed [COEF_W-1:0] x, y;

  logic [31:0] lfsr_state = 32'h8556;
  int          raw_m [6];                        // b0 b1 b2 a0 a1 a2
  int          nrm_exp [5];                      // b0 b1 b2 a1 a2
  int          hx1, hx2, hy1, hy2;               // Model history
  bit          bypass_m;

  biquad_top dut0 (.*);

  always #(CLK_NS / 2) clk = ~clk;

  task automatic fail_with(input string line);
    $display("%s", line);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    fail_with($sformatf("ERR %0t %s expected 'h%0h got 'h%0h", $time, name, exp, got));
  endtask

  // --------------------------------------------------
  // Random source and reference model
  // --------------------------------------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic int rand_signed(input int n);
    logic [31:0] v;
    v = rand_bits(n);
    if (v[n-1]) v = v | (32'hFFFF_FFFF << n);    // Sign extend
    return int'(v);
  endfunction

  function automatic logic [31:0] sext16(input int v);
    return 32'($signed(16'(v)));
  endfunction

  function automatic int ref_div(input int dd, input int dv);
    longint q;
    if (dv == 0) return (dd < 0) ? COEF_MIN : COEF_MAX;
    q = (longint'(dd) * ONE_Q) / dv;             // Truncates toward zero
    if (q > COEF_MAX) return COEF_MAX;
    if (q < COEF_MIN) return COEF_MIN;
    return int'(q);
  endfunction

  function automatic int model_filter(input int xin, input bit byp);
    longint acc;
    int     yf;
    acc = longint'(nrm_exp[0]) * xin + longint'(nrm_exp[1]) * hx1
        + longint'(nrm_exp[2]) * hx2 - longint'(nrm_exp[3]) * hy1
        - longint'(nrm_exp[4]) * hy2;
    acc = acc >>> Q_BITS;
    yf  = (acc > COEF_MAX) ? COEF_MAX : (acc < COEF_MIN) ? COEF_MIN : int'(acc);
    hx2 = hx1;
    hx1 = xin;
    hy2 = hy1;
    hy1 = yf;                                    // Filtered value even in bypass
    return byp ? xin : yf;
  endfunction

  function automatic void update_expected();
    for (int k = 0; k < 5; k++) nrm_exp[k] = ref_div(raw_m[k < 3 ? k : k + 1], raw_m[3]);
  endfunction

  // --------------------------------------------------
  // APB access
  // --------------------------------------------------
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input bit err);
    @(negedge clk);
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;
    #1;
    assert (pready === 1'b1) else report_mismatch("pready", 1, pready);
    assert (pslverr === err) else report_mismatch("pslverr", err, pslverr);
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, input bit err);
    @(negedge clk);
    psel = 1'b1;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge clk);
    penable = 1'b1;
    #1;                                          // Sample mid access phase
    data = prdata;
    assert (pslverr === err) else report_mismatch("pslverr", err, pslverr);
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic expect_reg(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] d;
    apb_read(addr, d, 1'b0);
    assert (d === exp) else report_mismatch($sformatf("prdata@%02h", addr), exp, d);
  endtask

  task automatic write_raw(input int i, input logic [31:0] data);
    apb_write(8'(REG_RAW_B0 + 4 * i), data, 1'b0);
    raw_m[i] = int'($signed(data[15:0]));
  endtask

  task automatic rand_raw_set();
    for (int i = 0; i < 6; i++)
      write_raw(i, (i == 3) ? ONE_Q + rand_bits(12) : rand_signed(i < 3 ? 14 : 13));
  endtask

  task automatic check_nrm();
    for (int k = 0; k < 5; k++) expect_reg(8'(REG_NRM_B0 + 4 * k), sext16(nrm_exp[k]));
  endtask

  // Needs two idle reads in a row since the gap between queued runs is shorter
  task automatic wait_idle();
    logic [31:0] d;
    int          zeros;
    int          polls;
    zeros = 0;
    polls = 0;
    while (zeros < 2) begin
      apb_read(REG_STATUS, d, 1'b0);
      zeros = d[0] ? 0 : zeros + 1;
      polls++;
      if (polls > MAX_POLLS) fail_with("busy in REG_STATUS never cleared");
    end
  endtask

  task automatic wait_busy();
    logic [31:0] d;
    int          polls;
    polls = 0;
    d = '0;
    while (!d[0]) begin
      apb_read(REG_STATUS, d, 1'b0);
      polls++;
      if (polls > 20) fail_with("busy in REG_STATUS never went high");
    end
  endtask

  // --------------------------------------------------
  // Sample stream
  // --------------------------------------------------
  task automatic run_stream(input int n, input int xbits, input bit gaps);
    bit prev;
    int exp_y;
    int xin;
    prev = 1'b0;
    for (int i = 0; i <= n; i++) begin
      @(negedge clk);
      if (prev) begin
        assert (y_valid === 1'b1) else report_mismatch("y_valid", 1, y_valid);
        assert (y === 16'(exp_y)) else report_mismatch("y", exp_y, 32'(y));
      end
      prev = (i < n) && (!gaps || rand_bits(2) != 0);
      x_valid = prev;
      if (prev) begin
        xin   = rand_signed(xbits);
        x     = 16'(xin);
        exp_y = model_filter(xin, bypass_m);
      end
    end
  endtask

  initial begin
    logic [31:0] d;
    int          base;
    clk = 1'b0;
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    x_valid = 1'b0;
    x = '0;
    raw_m = '{ONE_Q, 0, 0, ONE_Q, 0, 0};
    nrm_exp = '{ONE_Q, 0, 0, 0, 0};
    {hx1, hx2, hy1, hy2} = '0;
    bypass_m = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;

    // Reset state is an identity filter
    check_nrm();
    expect_reg(REG_OVF_CNT, 0);
    expect_reg(REG_CTRL, 0);
    run_stream(16, COEF_W, 1'b0);

    // Register access and error responses
    for (int i = 0; i < 6; i++) write_raw(i, rand_bits(32));
    for (int i = 0; i < 6; i++) expect_reg(8'(REG_RAW_B0 + 4 * i), sext16(raw_m[i]));
    wait_idle();
    update_expected();
    apb_read(REG_OVF_CNT, d, 1'b0);
    base = int'(d);
    for (int i = 0; i < 5; i++) begin
      apb_write(BAD_ADDR[i], rand_bits(32), 1'b1);
      apb_read(BAD_ADDR[i], d, 1'b1);
    end
    apb_write(REG_STATUS, 32'h1, 1'b1);
    apb_write(REG_NRM_B0, rand_bits(32), 1'b1);
    apb_write(REG_OVF_CNT, 32'h0, 1'b1);
    for (int i = 0; i < 6; i++) expect_reg(8'(REG_RAW_B0 + 4 * i), sext16(raw_m[i]));
    expect_reg(REG_CTRL, 0);
    expect_reg(REG_OVF_CNT, base);
    check_nrm();

    // Normalization and a write during a run
    rand_raw_set();
    wait_idle();
    update_expected();
    check_nrm();
    rand_raw_set();
    wait_busy();
    write_raw(1, rand_signed(14));
    write_raw(4, rand_signed(13));
    wait_idle();
    update_expected();
    check_nrm();

    run_stream(64, 13, 1'b1);

    // Zero a0 saturates all five quotients
    apb_read(REG_OVF_CNT, d, 1'b0);
    base = int'(d);
    write_raw(3, 0);
    wait_idle();
    update_expected();
    check_nrm();
    expect_reg(REG_OVF_CNT, base + 5);

    // Bypass followed by filtering from the history built meanwhile
    write_raw(3, ONE_Q + rand_bits(12));
    wait_idle();
    update_expected();
    check_nrm();
    apb_write(REG_CTRL, 32'h1, 1'b0);
    bypass_m = 1'b1;
    expect_reg(REG_CTRL, 1);
    run_stream(24, COEF_W, 1'b1);
    apb_write(REG_CTRL, 32'h0, 1'b0);
    bypass_m = 1'b0;
    run_stream(32, 13, 1'b0);

    repeat (2) @(negedge clk);
    if (dut0.u_chk.err_cnt != 0) begin
      fail_with("a bound assertion failed");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

  initial begin
    wait (dut0.u_chk.err_cnt != 0);
    fail_with("a bound assertion in biquad_chk failed");
  end

  initial begin
    #(WATCHDOG_NS);
    fail_with("watchdog expired before the tests finished");
  end

endmodule

/* biquad.f */
design/biquad_pkg.sv
design/biquad_apb_regs.sv
design/coef_sequencer.sv
design/serial_divider.sv
design/biquad_core.sv
design/biquad_top.sv
verif/biquad_chk.sv
verif/tb_biquad.sv

/* Bender.yml */
package:
  name: biquad

sources:
  - design/biquad_pkg.sv
  - design/biquad_apb_regs.sv
  - design/coef_sequencer.sv
  - design/serial_divider.sv
  - design/biquad_core.sv
  - design/biquad_top.sv
  - target: simulation
    files:
      - verif/biquad_chk.sv
      - verif/tb_biquad.sv
